// File: Bender.yml
package:
  name: lcd_scan

sources:
  - hdl/lcd_pkg.sv
  - hdl/line_fetch_if.sv
  - hdl/scan_timing.sv
  - hdl/pixel_sequencer.sv
  - hdl/burst_fetch_ctrl.sv
  - hdl/pixel_fifo.sv
  - hdl/palette_out.sv
  - hdl/lcd_scan_top.sv
  - target: simulation
    files:
      - sim/tb_lcd_scan.sv

// File: hdl/burst_fetch_ctrl.sv
// Cache and memory burst fetch controller
`timescale 1ns/100ps

module burst_fetch_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  line_fetch_if.server                fetch,
  // Direct cache port
  output logic                        dcb_stb_o,
  output logic [lcd_pkg::ADDR_W-1:0]  dcb_adr_o,
  input  logic [lcd_pkg::WORD_W-1:0]  dcb_dat_i,
  input  logic                        dcb_hit_i,
  // External memory port
  output logic                        mem_stb_o,
  output logic [lcd_pkg::ADDR_W-1:0]  mem_adr_o,
  input  logic                        mem_ack_i,
  input  logic [lcd_pkg::WORD_W-1:0]  mem_dat_i
);

  lcd_pkg::fetch_state_t       state_q;
  lcd_pkg::fetch_state_t       state_d;
  logic [lcd_pkg::ADDR_W-1:0]  line_addr;
  logic [lcd_pkg::WIDX_W-1:0]  probe_idx;
  logic [lcd_pkg::WIDX_W-1:0]  word_cnt;
  logic                        accept;
  logic                        from_mem;
  logic                        last_word;

  assign accept    = fetch.req_valid && fetch.req_ready;
  assign last_word = fetch.word_valid && (word_cnt == lcd_pkg::BURST_LEN - 1);

  // ================================================
  // State register and next state
  // ================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= lcd_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      lcd_pkg::IDLE:
        if (fetch.req_valid) state_d = lcd_pkg::TRY_CACHE;
      lcd_pkg::TRY_CACHE:
        state_d = lcd_pkg::CACHE_CHECK;
      // A hit means the rest of the burst hits too
      lcd_pkg::CACHE_CHECK:
        state_d = dcb_hit_i ? lcd_pkg::CACHE_STREAM : lcd_pkg::MEM_REQ;
      lcd_pkg::CACHE_STREAM:
        if (last_word) state_d = lcd_pkg::IDLE;
      lcd_pkg::MEM_REQ:
        if (mem_ack_i) state_d = lcd_pkg::MEM_STREAM;
      lcd_pkg::MEM_STREAM:
        if (last_word) state_d = lcd_pkg::IDLE;
      default:
        state_d = lcd_pkg::IDLE;
    endcase
  end

  // Line address latched on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      line_addr <= fetch.req_addr;
    end
  end

  // ================================================
  // Cache probe
  // ================================================
  // Probe index runs while the strobe is held
  always_ff @(posedge clk) begin
    if (rst || !dcb_stb_o) begin
      probe_idx <= '0;
    end else begin
      probe_idx <= probe_idx + 1'b1;
    end
  end

  // Strobe released once address 7 has been presented
  assign dcb_stb_o = (state_q == lcd_pkg::TRY_CACHE) ||
                     ((state_q == lcd_pkg::CACHE_CHECK) && dcb_hit_i) ||
                     ((state_q == lcd_pkg::CACHE_STREAM) &&
                      (word_cnt != lcd_pkg::BURST_LEN - 1));
  assign dcb_adr_o = line_addr +
                     {{(lcd_pkg::ADDR_W - lcd_pkg::WIDX_W){1'b0}}, probe_idx};

  // Memory strobe held until ack
  assign mem_stb_o = (state_q == lcd_pkg::MEM_REQ);
  assign mem_adr_o = line_addr;

  // ================================================
  // Word return
  // ================================================
  always_ff @(posedge clk) begin
    if (rst || accept) begin
      word_cnt <= '0;
    end else if (fetch.word_valid) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  assign from_mem = (state_q == lcd_pkg::MEM_REQ) || (state_q == lcd_pkg::MEM_STREAM);

  assign fetch.req_ready  = (state_q == lcd_pkg::IDLE);
  assign fetch.word_valid = ((state_q == lcd_pkg::CACHE_CHECK) && dcb_hit_i) ||
                            (state_q == lcd_pkg::CACHE_STREAM) ||
                            ((state_q == lcd_pkg::MEM_REQ) && mem_ack_i) ||
                            (state_q == lcd_pkg::MEM_STREAM);
  assign fetch.word_idx   = word_cnt;
  assign fetch.word_data  = from_mem ? mem_dat_i : dcb_dat_i;

endmodule

// File: hdl/lcd_pkg.sv
// LCD scan-out shared definitions
package lcd_pkg;

  // ================================================
  // Bus widths
  // ================================================
  localparam int ADDR_W  = 20;
  localparam int WORD_W  = 16;
  localparam int PIX_W   = 4;
  localparam int COLOR_W = 12;
  // One color channel, 4 bits each of R, G, B
  localparam int CHAN_W  = COLOR_W / 3;

  // Burst covers one whole active line
  localparam int BURST_LEN = 8;
  localparam int WIDX_W    = $clog2(BURST_LEN);
  // Nibble select bits inside one word
  localparam int NIB_W     = $clog2(WORD_W / PIX_W);

  // ================================================
  // Raster, kept small for simulation
  // ================================================
  localparam int H_ACTIVE    = 32;
  localparam int H_TOTAL     = 40;
  localparam int HSYNC_START = 34;
  localparam int HSYNC_END   = 37;
  localparam int V_ACTIVE    = 4;
  localparam int V_TOTAL     = 6;
  localparam int VSYNC_LINE  = 5;
  localparam int H_W         = $clog2(H_TOTAL);
  localparam int V_W         = $clog2(V_TOTAL);

  // Clocks per dot and pixel buffer depth
  localparam int PIX_DIV    = 4;
  localparam int FIFO_DEPTH = 16;

  // One pixel as it travels to the panel
  typedef struct packed {
    logic             hsync;
    logic             vsync;
    logic             active;
    logic [PIX_W-1:0] index;
  } pixel_t;

  // Fetch controller states
  typedef enum logic [2:0] {
    IDLE,
    TRY_CACHE,
    CACHE_CHECK,
    CACHE_STREAM,
    MEM_REQ,
    MEM_STREAM
  } fetch_state_t;

endpackage

// File: hdl/lcd_scan_top.sv
// LCD scan-out engine top level
`timescale 1ns/100ps

module lcd_scan_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [lcd_pkg::ADDR_W-1:0]   base_addr_i,
  // Direct cache port
  output logic                         dcb_stb_o,
  output logic [lcd_pkg::ADDR_W-1:0]   dcb_adr_o,
  input  logic [lcd_pkg::WORD_W-1:0]   dcb_dat_i,
  input  logic                         dcb_hit_i,
  // External memory port
  output logic                         mem_stb_o,
  output logic [lcd_pkg::ADDR_W-1:0]   mem_adr_o,
  input  logic                         mem_ack_i,
  input  logic [lcd_pkg::WORD_W-1:0]   mem_dat_i,
  // Palette write port
  input  logic                         pal_we_i,
  input  logic [lcd_pkg::PIX_W-1:0]    pal_addr_i,
  input  logic [lcd_pkg::COLOR_W-1:0]  pal_data_i,
  // Panel
  output logic [lcd_pkg::CHAN_W-1:0]   red_o,
  output logic [lcd_pkg::CHAN_W-1:0]   green_o,
  output logic [lcd_pkg::CHAN_W-1:0]   blue_o,
  output logic                         hsync_o,
  output logic                         vsync_o,
  output logic                         pix_en_o
);

  lcd_pkg::pixel_t seq_pix;
  lcd_pkg::pixel_t fifo_pix;
  logic            seq_valid;
  logic            seq_ready;
  logic            fifo_valid;
  logic            fifo_ready;

  line_fetch_if fetch_bus ();

  // ================================================
  // Raster and line fetch
  // ================================================
  pixel_sequencer u_seq (
    .clk         (clk),
    .rst         (rst),
    .base_addr_i (base_addr_i),
    .fetch       (fetch_bus),
    .pix_valid_o (seq_valid),
    .pix_ready_i (seq_ready),
    .pix_o       (seq_pix)
  );

  // Cache first, memory burst on a miss
  burst_fetch_ctrl u_fetch (
    .clk       (clk),
    .rst       (rst),
    .fetch     (fetch_bus),
    .dcb_stb_o (dcb_stb_o),
    .dcb_adr_o (dcb_adr_o),
    .dcb_dat_i (dcb_dat_i),
    .dcb_hit_i (dcb_hit_i),
    .mem_stb_o (mem_stb_o),
    .mem_adr_o (mem_adr_o),
    .mem_ack_i (mem_ack_i),
    .mem_dat_i (mem_dat_i)
  );

  // ================================================
  // Pixel buffer and output stage
  // ================================================
  pixel_fifo #(
    .DEPTH (lcd_pkg::FIFO_DEPTH),
    .T     (lcd_pkg::pixel_t)
  ) u_fifo (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (seq_valid),
    .in_ready_o  (seq_ready),
    .in_data_i   (seq_pix),
    .out_valid_o (fifo_valid),
    .out_ready_i (fifo_ready),
    .out_data_o  (fifo_pix)
  );

  palette_out u_pal (
    .clk         (clk),
    .rst         (rst),
    .pix_valid_i (fifo_valid),
    .pix_ready_o (fifo_ready),
    .pix_i       (fifo_pix),
    .pal_we_i    (pal_we_i),
    .pal_addr_i  (pal_addr_i),
    .pal_data_i  (pal_data_i),
    .red_o       (red_o),
    .green_o     (green_o),
    .blue_o      (blue_o),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o),
    .pix_en_o    (pix_en_o)
  );

endmodule

// File: hdl/line_fetch_if.sv
// Line fetch bus
`timescale 1ns/100ps

interface line_fetch_if;

  // Request side, valid/ready
  logic                        req_valid;
  logic                        req_ready;
  // First word of the line, stable while req_valid
  logic [lcd_pkg::ADDR_W-1:0]  req_addr;

  // Word return, no back-pressure
  logic                        word_valid;
  logic [lcd_pkg::WIDX_W-1:0]  word_idx;
  logic [lcd_pkg::WORD_W-1:0]  word_data;

  // Pixel sequencer side
  modport requester (
    output req_valid, req_addr,
    input  req_ready, word_valid, word_idx, word_data
  );

  // Fetch controller side
  modport server (
    input  req_valid, req_addr,
    output req_ready, word_valid, word_idx, word_data
  );

endinterface

// File: hdl/palette_out.sv
// Palette lookup and panel output stage
`timescale 1ns/100ps

module palette_out (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         pix_valid_i,
  output logic                         pix_ready_o,
  input  lcd_pkg::pixel_t              pix_i,
  // Palette write port
  input  logic                         pal_we_i,
  input  logic [lcd_pkg::PIX_W-1:0]    pal_addr_i,
  input  logic [lcd_pkg::COLOR_W-1:0]  pal_data_i,
  // Panel
  output logic [lcd_pkg::CHAN_W-1:0]   red_o,
  output logic [lcd_pkg::CHAN_W-1:0]   green_o,
  output logic [lcd_pkg::CHAN_W-1:0]   blue_o,
  output logic                         hsync_o,
  output logic                         vsync_o,
  output logic                         pix_en_o
);

  logic [$clog2(lcd_pkg::PIX_DIV)-1:0] div_cnt;
  logic [lcd_pkg::COLOR_W-1:0]         palette [2 ** lcd_pkg::PIX_W];
  logic [lcd_pkg::COLOR_W-1:0]         color;
  logic                                pop;

  // ================================================
  // Dot clock pacing
  // ================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= (div_cnt == lcd_pkg::PIX_DIV - 1) ? '0 : div_cnt + 1'b1;
    end
  end

  // One slot every PIX_DIV clocks, empty FIFO skips the slot
  assign pix_ready_o = (div_cnt == '0);
  assign pop         = pix_ready_o && pix_valid_i;

  // Palette RAM
  always_ff @(posedge clk) begin
    if (pal_we_i) begin
      palette[pal_addr_i] <= pal_data_i;
    end
  end

  // ================================================
  // Registered panel outputs
  // ================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      color    <= '0;
      hsync_o  <= 1'b0;
      vsync_o  <= 1'b0;
      pix_en_o <= 1'b0;
    end else begin
      pix_en_o <= pop;
      if (pop) begin
        // Blank outside the active region
        color   <= pix_i.active ? palette[pix_i.index] : '0;
        hsync_o <= pix_i.hsync;
        vsync_o <= pix_i.vsync;
      end
    end
  end

  assign red_o   = color[2*lcd_pkg::CHAN_W +: lcd_pkg::CHAN_W];
  assign green_o = color[lcd_pkg::CHAN_W +: lcd_pkg::CHAN_W];
  assign blue_o  = color[0 +: lcd_pkg::CHAN_W];

endmodule

// File: hdl/pixel_fifo.sv
// Synchronous FIFO with generic payload
`timescale 1ns/100ps

module pixel_fifo #(
  parameter int  DEPTH = 16,
  parameter type T     = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  T                mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            push;
  logic            pop;

  assign in_ready_o  = (count != DEPTH);
  assign out_valid_o = (count != 0);
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  // Pointers wrap at DEPTH, count tracks occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Push with pop leaves count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  assign out_data_o = mem[rd_ptr];

endmodule

// File: hdl/pixel_sequencer.sv
// Pixel sequencer
`timescale 1ns/100ps

module pixel_sequencer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [lcd_pkg::ADDR_W-1:0]   base_addr_i,
  line_fetch_if.requester              fetch,
  output logic                         pix_valid_o,
  input  logic                         pix_ready_i,
  output lcd_pkg::pixel_t              pix_o
);

  logic [lcd_pkg::H_W-1:0]    h_count;
  logic [lcd_pkg::V_W-1:0]    v_count;
  logic                       hsync;
  logic                       vsync;
  logic                       active;
  logic                       step;
  logic                       loaded;
  logic                       fetching;
  logic                       req_valid_q;
  logic                       need_fetch;
  logic                       word_last;
  logic [lcd_pkg::ADDR_W-1:0] line_off;
  logic [lcd_pkg::WORD_W-1:0] line_buf [lcd_pkg::BURST_LEN];
  logic [lcd_pkg::WORD_W-1:0] cur_word;

  scan_timing u_timing (
    .clk       (clk),
    .rst       (rst),
    .step_i    (step),
    .h_count_o (h_count),
    .v_count_o (v_count),
    .hsync_o   (hsync),
    .vsync_o   (vsync),
    .active_o  (active)
  );

  // ================================================
  // Line fetch requests
  // ================================================
  // Line number times BURST_LEN
  assign line_off = {{(lcd_pkg::ADDR_W - lcd_pkg::V_W - lcd_pkg::WIDX_W){1'b0}},
                     v_count, {lcd_pkg::WIDX_W{1'b0}}};

  // First pixel of an active line, nothing loaded or in flight
  assign need_fetch = active && (h_count == '0) && !loaded && !fetching;
  assign word_last  = fetch.word_valid && (fetch.word_idx == lcd_pkg::BURST_LEN - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_q <= 1'b0;
      fetching    <= 1'b0;
      loaded      <= 1'b0;
    end else begin
      if (need_fetch) begin
        req_valid_q <= 1'b1;
        fetching    <= 1'b1;
      end else if (req_valid_q && fetch.req_ready) begin
        req_valid_q <= 1'b0;
      end
      // Loaded after word 7, dropped at end of line
      if (word_last) begin
        loaded   <= 1'b1;
        fetching <= 1'b0;
      end else if (step && (h_count == lcd_pkg::H_TOTAL - 1)) begin
        loaded <= 1'b0;
      end
    end
  end

  // Address sampled as the request is formed
  always_ff @(posedge clk) begin
    if (need_fetch) begin
      fetch.req_addr <= base_addr_i + line_off;
    end
  end

  assign fetch.req_valid = req_valid_q;

  // Line word buffer
  always_ff @(posedge clk) begin
    if (fetch.word_valid) begin
      line_buf[fetch.word_idx] <= fetch.word_data;
    end
  end

  // ================================================
  // Pixel output
  // ================================================
  assign cur_word = line_buf[h_count[lcd_pkg::NIB_W +: lcd_pkg::WIDX_W]];

  // Stall only while the active line waits for its words
  assign pix_valid_o = !(active && !loaded);
  assign step        = pix_valid_o && pix_ready_i;

  always_comb begin
    pix_o.hsync  = hsync;
    pix_o.vsync  = vsync;
    pix_o.active = active;
    // Lowest nibble first
    pix_o.index  = active ? cur_word[h_count[lcd_pkg::NIB_W-1:0] * lcd_pkg::PIX_W +:
                                     lcd_pkg::PIX_W]
                          : '0;
  end

endmodule

// File: hdl/scan_timing.sv
// Raster counters
`timescale 1ns/100ps

module scan_timing (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     step_i,
  output logic [lcd_pkg::H_W-1:0]  h_count_o,
  output logic [lcd_pkg::V_W-1:0]  v_count_o,
  output logic                     hsync_o,
  output logic                     vsync_o,
  output logic                     active_o
);

  logic h_wrap;
  logic v_wrap;

  assign h_wrap = (h_count_o == lcd_pkg::H_TOTAL - 1);
  assign v_wrap = (v_count_o == lcd_pkg::V_TOTAL - 1);

  // ================================================
  // Pixel and line counters
  // ================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      h_count_o <= '0;
      v_count_o <= '0;
    end else if (step_i) begin
      if (h_wrap) begin
        h_count_o <= '0;
        // Line advances with the last pixel
        v_count_o <= v_wrap ? '0 : v_count_o + 1'b1;
      end else begin
        h_count_o <= h_count_o + 1'b1;
      end
    end
  end

  // Decode for the current pixel, not yet emitted
  assign hsync_o  = (h_count_o >= lcd_pkg::HSYNC_START) &&
                    (h_count_o <= lcd_pkg::HSYNC_END);
  assign vsync_o  = (v_count_o == lcd_pkg::VSYNC_LINE);
  assign active_o = (h_count_o < lcd_pkg::H_ACTIVE) &&
                    (v_count_o < lcd_pkg::V_ACTIVE);

endmodule

// File: lcd_scan.f
hdl/lcd_pkg.sv
hdl/line_fetch_if.sv
hdl/scan_timing.sv
hdl/pixel_sequencer.sv
hdl/burst_fetch_ctrl.sv
hdl/pixel_fifo.sv
hdl/palette_out.sv
hdl/lcd_scan_top.sv
sim/tb_lcd_scan.sv

// File: sim/tb_lcd_scan.sv
// LCD scan-out testbench
`timescale 1ns/100ps

module tb_lcd_scan;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_FRAMES = 4;
  localparam int MEM_AW     = 10;
  localparam int MEM_WORDS  = 1 << MEM_AW;
  localparam int PAL_SIZE   = 2 ** lcd_pkg::PIX_W;
  localparam logic [31:0] SEED = 32'd71507;
  // Twice the nominal run plus an ack allowance per line
  localparam int WATCHDOG_CYCLES =
    2 * (NUM_FRAMES * lcd_pkg::H_TOTAL * lcd_pkg::V_TOTAL * lcd_pkg::PIX_DIV +
         NUM_FRAMES * lcd_pkg::V_TOTAL * 40);

  logic                          clk;
  logic                          rst;
  logic [lcd_pkg::ADDR_W-1:0]    base_addr_i;
  logic                          dcb_stb_o;
  logic [lcd_pkg::ADDR_W-1:0]    dcb_adr_o;
  logic [lcd_pkg::WORD_W-1:0]    dcb_dat_i;
  logic                          dcb_hit_i;
  logic                          mem_stb_o;
  logic [lcd_pkg::ADDR_W-1:0]    mem_adr_o;
  logic                          mem_ack_i;
  logic [lcd_pkg::WORD_W-1:0]    mem_dat_i;
  logic                          pal_we_i;
  logic [lcd_pkg::PIX_W-1:0]     pal_addr_i;
  logic [lcd_pkg::COLOR_W-1:0]   pal_data_i;
  logic [lcd_pkg::CHAN_W-1:0]    red_o;
  logic [lcd_pkg::CHAN_W-1:0]    green_o;
  logic [lcd_pkg::CHAN_W-1:0]    blue_o;
  logic                          hsync_o;
  logic                          vsync_o;
  logic                          pix_en_o;

  // Shared image behind both cache and memory
  logic [lcd_pkg::WORD_W-1:0]    mem_words [MEM_WORDS];
  logic [lcd_pkg::COLOR_W-1:0]   exp_pal [PAL_SIZE];
  logic [31:0]                   lfsr_q;

  // Stimulus state
  int frame_no;
  int pal_cnt;
  int mem_wait;
  int mem_beat;
  int mem_base;
  int pending_base;
  bit models_ready;
  bit in_vsync;
  bit cache_burst;
  bit expect_mem;
  bit mem_armed;
  bit hit;

  // Panel model state
  int exp_h;
  int exp_v;
  int frame_base;
  int frames_done;
  int cycle_cnt;
  int last_en;
  int pix_checked;
  int gap_cnt;
  int hit_cnt;
  int miss_cnt;
  int mismatch_cnt;
  int fail_cnt;

  lcd_scan_top UUT (
    .clk         (clk),
    .rst         (rst),
    .base_addr_i (base_addr_i),
    .dcb_stb_o   (dcb_stb_o),
    .dcb_adr_o   (dcb_adr_o),
    .dcb_dat_i   (dcb_dat_i),
    .dcb_hit_i   (dcb_hit_i),
    .mem_stb_o   (mem_stb_o),
    .mem_adr_o   (mem_adr_o),
    .mem_ack_i   (mem_ack_i),
    .mem_dat_i   (mem_dat_i),
    .pal_we_i    (pal_we_i),
    .pal_addr_i  (pal_addr_i),
    .pal_data_i  (pal_data_i),
    .red_o       (red_o),
    .green_o     (green_o),
    .blue_o      (blue_o),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o),
    .pix_en_o    (pix_en_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==================================================
  // Random numbers and checks
  // ==================================================
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic int unsigned rand_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = (r << 1) | lfsr_q[0];
    end
    return r;
  endfunction

  // Frame 0 hits, frames 1 and 3 miss, frame 2 draws a mix
  function automatic bit pick_hit(input int frame);
    if (frame == 0) return 1'b1;
    if (frame == 1) return 1'b0;
    if (frame >= 3) return 1'b0;
    return rand_bits(1);
  endfunction

  // Last frame waits long enough to drain the pixel FIFO
  function automatic int draw_delay(input int frame);
    if (frame >= 3) return 60 + (rand_bits(6) % 41);
    return rand_bits(6) % 41;
  endfunction

  // Lowest nibble of a word is the leftmost pixel
  function automatic logic [lcd_pkg::PIX_W-1:0] expected_index(input int h, input int v);
    int                         addr;
    logic [lcd_pkg::WORD_W-1:0] word;
    addr = (frame_base + v * lcd_pkg::BURST_LEN + h / 4) % MEM_WORDS;
    word = mem_words[addr];
    return word[(h % 4) * lcd_pkg::PIX_W +: lcd_pkg::PIX_W];
  endfunction

  task automatic compare_color(input string name,
                               input logic [lcd_pkg::COLOR_W-1:0] got,
                               input logic [lcd_pkg::COLOR_W-1:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic protocol_error(input string msg);
    fail_cnt++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // ==================================================
  // Palette, cache and memory models
  // ==================================================
  always @(posedge clk) begin
    if (rst) begin
      pal_cnt      = 0;
      models_ready = 1'b0;
      in_vsync     = 1'b0;
      cache_burst  = 1'b0;
      expect_mem   = 1'b0;
      mem_armed    = 1'b0;
      mem_beat     = 0;
      frame_no     = 0;
    end else begin
      // First vsync pixel opens the rewrite window
      if (pix_en_o && vsync_o && !in_vsync) begin
        in_vsync     = 1'b1;
        frame_no++;
        pal_cnt      = 0;
        pending_base = rand_bits(9);
        base_addr_i <= pending_base;
      end else if (pix_en_o && !vsync_o) begin
        in_vsync = 1'b0;
      end

      // One palette entry per clock
      pal_we_i <= 1'b0;
      if (pal_cnt < PAL_SIZE) begin
        exp_pal[pal_cnt] = rand_bits(lcd_pkg::COLOR_W);
        pal_we_i   <= 1'b1;
        pal_addr_i <= pal_cnt;
        pal_data_i <= exp_pal[pal_cnt];
        pal_cnt++;
        if (pal_cnt == PAL_SIZE) models_ready = 1'b1;
      end

      // Cache answers the probe one cycle later and stays cold until the palette is loaded
      if (dcb_stb_o) begin
        if (!cache_burst) begin
          if (expect_mem) protocol_error("cache miss was not followed by a memory request");
          hit         = models_ready && pick_hit(frame_no);
          cache_burst = hit;
          expect_mem  = !hit;
          if (hit) hit_cnt++;
        end
        dcb_hit_i <= cache_burst;
        dcb_dat_i <= mem_words[dcb_adr_o[MEM_AW-1:0]];
      end else begin
        cache_burst = 1'b0;
        dcb_hit_i  <= 1'b0;
      end

      // Memory acks with word 0 and returns 7 more words back to back
      mem_ack_i <= 1'b0;
      if (mem_beat != 0) begin
        mem_dat_i <= mem_words[(mem_base + mem_beat) % MEM_WORDS];
        mem_beat = (mem_beat == lcd_pkg::BURST_LEN - 1) ? 0 : mem_beat + 1;
      end else if (mem_stb_o) begin
        if (!mem_armed) begin
          if (!expect_mem) protocol_error("memory request without a preceding cache miss");
          expect_mem = 1'b0;
          mem_armed  = 1'b1;
          mem_wait   = draw_delay(frame_no);
          miss_cnt++;
        end
        if (models_ready && mem_wait == 0) begin
          mem_ack_i <= 1'b1;
          mem_dat_i <= mem_words[mem_adr_o[MEM_AW-1:0]];
          mem_base  = mem_adr_o;
          mem_beat  = 1;
          mem_armed = 1'b0;
        end else if (models_ready) begin
          mem_wait--;
        end
      end else if (mem_armed) begin
        protocol_error("memory strobe dropped before ack");
        mem_armed = 1'b0;
      end
    end
  end

  // ==================================================
  // Panel model
  // ==================================================
  always @(posedge clk) begin
    logic                        exp_hs;
    logic                        exp_vs;
    logic [lcd_pkg::COLOR_W-1:0] exp_col;
    cycle_cnt++;
    if (!rst && pix_en_o) begin
      if (cycle_cnt - last_en < lcd_pkg::PIX_DIV) begin
        protocol_error("pixel enables closer than one dot period");
      end
      // Wider spacing after the first pixel means the FIFO ran dry
      if (pix_checked > 0 && cycle_cnt - last_en > lcd_pkg::PIX_DIV) begin
        gap_cnt++;
      end
      last_en = cycle_cnt;
      exp_hs  = (exp_h >= lcd_pkg::HSYNC_START) && (exp_h <= lcd_pkg::HSYNC_END);
      exp_vs  = (exp_v == lcd_pkg::VSYNC_LINE);
      if (exp_h < lcd_pkg::H_ACTIVE && exp_v < lcd_pkg::V_ACTIVE) begin
        exp_col = exp_pal[expected_index(exp_h, exp_v)];
      end else begin
        exp_col = '0;
      end
      compare_color("red_o/green_o/blue_o", {red_o, green_o, blue_o}, exp_col);
      compare_bit("hsync_o", hsync_o, exp_hs);
      compare_bit("vsync_o", vsync_o, exp_vs);
      pix_checked++;
      // Advance the raster and take the new base at the frame boundary
      if (exp_h == lcd_pkg::H_TOTAL - 1) begin
        exp_h = 0;
        if (exp_v == lcd_pkg::V_TOTAL - 1) begin
          exp_v = 0;
          frames_done++;
          frame_base = pending_base;
        end else begin
          exp_v++;
        end
      end else begin
        exp_h++;
      end
    end
  end

  // ==================================================
  // Sequence and watchdog
  // ==================================================
  initial begin
    rst         = 1'b1;
    dcb_dat_i   = '0;
    dcb_hit_i   = 1'b0;
    mem_ack_i   = 1'b0;
    mem_dat_i   = '0;
    pal_we_i    = 1'b0;
    pal_addr_i  = '0;
    pal_data_i  = '0;
    last_en     = -lcd_pkg::PIX_DIV;
    lfsr_q      = SEED;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem_words[a] = rand_bits(lcd_pkg::WORD_W);
    end
    pending_base = rand_bits(9);
    frame_base   = pending_base;
    base_addr_i  = pending_base;

    repeat (4) @(posedge clk);
    // Outputs held quiet by reset
    compare_bit("dcb_stb_o", dcb_stb_o, 1'b0);
    compare_bit("mem_stb_o", mem_stb_o, 1'b0);
    compare_bit("pix_en_o", pix_en_o, 1'b0);
    compare_bit("hsync_o", hsync_o, 1'b0);
    compare_bit("vsync_o", vsync_o, 1'b0);
    compare_color("red_o/green_o/blue_o", {red_o, green_o, blue_o}, '0);
    rst <= 1'b0;

    while (frames_done < NUM_FRAMES) @(posedge clk);
    @(posedge clk);
    if (gap_cnt == 0) begin
      protocol_error("long memory waits never stalled the panel output");
    end
    $display("pixels %0d frames %0d hits %0d misses %0d gaps %0d mismatches %0d errors %0d",
             pix_checked, frames_done, hit_cnt, miss_cnt, gap_cnt, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles with %0d frames shown",
             WATCHDOG_CYCLES, frames_done);
    $display("tests failed");
    $finish;
  end

endmodule
